// ==== hw/periph_pkg.sv ====
// Shared widths, address constants and the I/O target type for the
// XT peripheral glue block. Files refer to these by scoped name.

package periph_pkg;

    // Bus widths
    localparam int ADDR_W    = 20;
    localparam int DATA_W    = 8;

    // EMS page registers
    localparam int EMS_PAGES = 4;
    localparam int EMS_MAP_W = 7;

    // I/O addresses
    // EMS registers occupy four consecutive ports from here
    localparam logic [15:0] EMS_IO_BASE = 16'h0260;
    localparam logic [15:0] LPT_IO_ADDR = 16'h0378;

    // Memory windows
    // BIOS at F0000-FFFFF, matched on address bits 19..16
    localparam logic [3:0] BIOS_WINDOW  = 4'hF;
    // Disk ROM at EC000-EFFFF, matched on address bits 19..14
    localparam logic [5:0] XTIDE_WINDOW = 6'b111011;

    // EMS write codes
    localparam logic [7:0] EMS_DISABLE_CODE = 8'hFF;
    // Bytes below this value map a page
    localparam logic [7:0] EMS_MAP_LIMIT    = 8'h80;

    // Device hit by the current I/O cycle
    typedef enum logic [2:0] {
        TGT_NONE,
        TGT_DMA,
        TGT_PIC,
        TGT_PIT,
        TGT_PPI,
        TGT_DMA_PAGE,
        TGT_EMS,
        TGT_LPT
    } io_target_e;

endpackage

// ==== hw/io_decoder.sv ====
// I/O and memory address decode for the peripheral block.
// Gives one I/O target per cycle plus active-low selects for the
// external chips and the two ROM windows. Purely combinational.

`timescale 1ns/1ps

module io_decoder (
    input  logic [periph_pkg::ADDR_W-1:0] address_i,
    input  logic                          address_enable_n_i,
    input  logic                          io_read_n_i,
    input  logic                          io_write_n_i,
    input  logic                          ems_enabled_i,
    output periph_pkg::io_target_e        target_o,
    output logic                          dma_cs_n_o,
    output logic                          pic_cs_n_o,
    output logic                          pit_cs_n_o,
    output logic                          ppi_cs_n_o,
    output logic                          dma_page_cs_n_o,
    output logic                          bios_cs_n_o,
    output logic                          xtide_cs_n_o
);

    logic iorq;
    logic io_cycle;
    logic mem_cycle;
    logic ext_space;
    logic ems_hit;
    logic lpt_hit;

    assign iorq      = !io_read_n_i || !io_write_n_i;
    assign io_cycle  = !address_enable_n_i && iorq;
    assign mem_cycle = !address_enable_n_i && !iorq;

    // Motherboard chips live in the first 256 ports
    assign ext_space = io_cycle && (address_i[9:8] == 2'b00);

    assign ems_hit = io_cycle && ems_enabled_i
                     && (address_i[15:2] == periph_pkg::EMS_IO_BASE[15:2]);
    assign lpt_hit = io_cycle && (address_i[15:0] == periph_pkg::LPT_IO_ADDR);

    always_comb begin
        target_o = periph_pkg::TGT_NONE;
        if (ext_space) begin
            // 32-byte blocks, only the first five are populated
            case (address_i[7:5])
                3'd0:    target_o = periph_pkg::TGT_DMA;
                3'd1:    target_o = periph_pkg::TGT_PIC;
                3'd2:    target_o = periph_pkg::TGT_PIT;
                3'd3:    target_o = periph_pkg::TGT_PPI;
                3'd4:    target_o = periph_pkg::TGT_DMA_PAGE;
                default: target_o = periph_pkg::TGT_NONE;
            endcase
        end else if (ems_hit) begin
            target_o = periph_pkg::TGT_EMS;
        end else if (lpt_hit) begin
            target_o = periph_pkg::TGT_LPT;
        end
    end

    // Chip selects follow the single target
    assign dma_cs_n_o      = (target_o != periph_pkg::TGT_DMA);
    assign pic_cs_n_o      = (target_o != periph_pkg::TGT_PIC);
    assign pit_cs_n_o      = (target_o != periph_pkg::TGT_PIT);
    assign ppi_cs_n_o      = (target_o != periph_pkg::TGT_PPI);
    assign dma_page_cs_n_o = (target_o != periph_pkg::TGT_DMA_PAGE);

    // ROM windows only on memory cycles
    assign bios_cs_n_o  = !(mem_cycle
                            && (address_i[19:16] == periph_pkg::BIOS_WINDOW));
    assign xtide_cs_n_o = !(mem_cycle
                            && (address_i[19:14] == periph_pkg::XTIDE_WINDOW));

endmodule

// ==== hw/ems_mapper.sv ====
// Four-page EMS mapper. Port writes go through a two-stage pipeline
// into the page registers; reads return the selected page, and the
// window hit outputs flag memory cycles into an enabled page.

`timescale 1ns/1ps

module ems_mapper (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [periph_pkg::ADDR_W-1:0]    address_i,
    input  logic [periph_pkg::DATA_W-1:0]    data_i,
    input  logic                             io_write_n_i,
    input  logic                             io_read_n_i,
    input  periph_pkg::io_target_e           target_i,
    input  logic [1:0]                       ems_base_i,
    output logic [periph_pkg::DATA_W-1:0]    read_data_o,
    output logic [periph_pkg::EMS_PAGES-1:0] window_hit_o
);

    localparam int IDX_W = $clog2(periph_pkg::EMS_PAGES);

    logic                            iorq;
    logic                            write_sample;
    logic [IDX_W-1:0]                page_sel;
    logic                            wr_valid_q;
    logic [IDX_W-1:0]                wr_index_q;
    logic [periph_pkg::DATA_W-1:0]   wr_data_q;
    logic [periph_pkg::EMS_MAP_W-1:0] map_q [periph_pkg::EMS_PAGES];
    logic [periph_pkg::EMS_PAGES-1:0] enable_q;
    logic [3:0]                      base_nibble;

    assign iorq         = !io_read_n_i || !io_write_n_i;
    assign write_sample = (target_i == periph_pkg::TGT_EMS) && !io_write_n_i;
    assign page_sel     = address_i[IDX_W-1:0];

    // Stage one: capture page index and written byte
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wr_valid_q <= 1'b0;
        end else begin
            wr_valid_q <= write_sample;
        end
    end

    always_ff @(posedge clock) begin
        if (write_sample) begin
            wr_index_q <= page_sel;
            wr_data_q  <= data_i;
        end
    end

    // Stage two: apply the write rules to the page
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            enable_q <= '0;
        end else if (wr_valid_q) begin
            if (wr_data_q == periph_pkg::EMS_DISABLE_CODE) begin
                enable_q[wr_index_q] <= 1'b0;
            end else if (wr_data_q < periph_pkg::EMS_MAP_LIMIT) begin
                enable_q[wr_index_q] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr_valid_q) begin
            if (wr_data_q == periph_pkg::EMS_DISABLE_CODE) begin
                map_q[wr_index_q] <= {periph_pkg::EMS_MAP_W{1'b1}};
            end else if (wr_data_q < periph_pkg::EMS_MAP_LIMIT) begin
                map_q[wr_index_q] <= wr_data_q[periph_pkg::EMS_MAP_W-1:0];
            end
            // Codes 80..FE are ignored
        end
    end

    // Disabled pages read as FF
    assign read_data_o = enable_q[page_sel]
        ? {{(periph_pkg::DATA_W - periph_pkg::EMS_MAP_W){1'b0}}, map_q[page_sel]}
        : {periph_pkg::DATA_W{1'b1}};

    // Frame segment at A000, C000 or D000
    always_comb begin
        case (ems_base_i)
            2'd0:    base_nibble = 4'hA;
            2'd1:    base_nibble = 4'hC;
            default: base_nibble = 4'hD;
        endcase
    end

    // 16 KB windows, one per page
    always_comb begin
        for (int k = 0; k < periph_pkg::EMS_PAGES; k++) begin
            window_hit_o[k] = !iorq && enable_q[k]
                              && (address_i[19:14] == {base_nibble, IDX_W'(k)});
        end
    end

    // Windows never overlap
    assert property (@(posedge clock) disable iff (reset)
        $onehot0(window_hit_o));

    // A sampled write has landed two edges later
    assert property (@(posedge clock) disable iff (reset)
        $past(write_sample, 2) |->
            (($past(data_i, 2) == periph_pkg::EMS_DISABLE_CODE)
                ? (!enable_q[$past(page_sel, 2)]
                   && (map_q[$past(page_sel, 2)] == {periph_pkg::EMS_MAP_W{1'b1}}))
                : ($past(data_i, 2) < periph_pkg::EMS_MAP_LIMIT)
                    ? (enable_q[$past(page_sel, 2)]
                       && (map_q[$past(page_sel, 2)]
                           == $past(data_i[periph_pkg::EMS_MAP_W-1:0], 2)))
                    : 1'b1));

endmodule

// ==== hw/keyboard_glue.sv ====
// Keyboard path conditioning. Keycode and irq are delayed through a
// sync pipeline, a rise of the keyboard reset line asks the PS/2
// sender for a reset, and the PS/2 clock is held low while busy.

`timescale 1ns/1ps

module keyboard_glue #(
    parameter int KEY_SYNC_STAGES = 2
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [periph_pkg::DATA_W-1:0] keycode_i,
    input  logic                          keyboard_irq_i,
    input  logic [periph_pkg::DATA_W-1:0] port_b_i,
    input  logic                          tandy_mode_i,
    input  logic                          ps2_send_clock_i,
    output logic [periph_pkg::DATA_W-1:0] port_a_o,
    output logic                          keyboard_interrupt_o,
    output logic                          send_request_o,
    output logic                          ps2_clock_out_o
);

    // Irq rides on top of the keycode
    localparam int PIPE_W = periph_pkg::DATA_W + 1;

    logic [PIPE_W-1:0] sync_q [KEY_SYNC_STAGES];
    logic              kbd_reset_n;
    logic              kbd_reset_n_q;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < KEY_SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= {keyboard_irq_i, keycode_i};
            for (int i = 1; i < KEY_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign port_a_o             = sync_q[KEY_SYNC_STAGES-1][periph_pkg::DATA_W-1:0];
    assign keyboard_interrupt_o = sync_q[KEY_SYNC_STAGES-1][periph_pkg::DATA_W];

    // Port B bit 6 holds the keyboard in reset; Tandy has no such line
    assign kbd_reset_n = tandy_mode_i ? 1'b1 : port_b_i[6];

    // Starts high so power-up does not look like a release
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            kbd_reset_n_q   <= 1'b1;
            send_request_o  <= 1'b0;
            ps2_clock_out_o <= 1'b1;
        end else begin
            kbd_reset_n_q   <= kbd_reset_n;
            send_request_o  <= kbd_reset_n && !kbd_reset_n_q;
            // Inhibit while a code is pending, sending, or held in reset
            ps2_clock_out_o <= !(keyboard_irq_i || !ps2_send_clock_i || !kbd_reset_n);
        end
    end

    // Reset request is a single-cycle pulse
    assert property (@(posedge clock) disable iff (reset)
        send_request_o |=> !send_request_o);

endmodule

// ==== hw/bus_readback.sv ====
// Parallel-port data latch and the registered readback byte that the
// chipset returns to the CPU. from_chipset_o tells the bus whether
// this block drives data on the current read.

`timescale 1ns/1ps

module bus_readback (
    input  logic                          clock,
    input  logic                          reset,
    input  periph_pkg::io_target_e        target_i,
    input  logic                          io_read_n_i,
    input  logic                          io_write_n_i,
    input  logic [periph_pkg::DATA_W-1:0] data_i,
    input  logic [periph_pkg::DATA_W-1:0] ems_data_i,
    output logic [periph_pkg::DATA_W-1:0] data_bus_o,
    output logic                          from_chipset_o
);

    logic [periph_pkg::DATA_W-1:0] lpt_data_q;
    logic                          ems_read;
    logic                          lpt_read;
    logic                          lpt_write;

    assign ems_read  = (target_i == periph_pkg::TGT_EMS) && !io_read_n_i;
    assign lpt_read  = (target_i == periph_pkg::TGT_LPT) && !io_read_n_i;
    assign lpt_write = (target_i == periph_pkg::TGT_LPT) && !io_write_n_i;

    // Printer data port idles with all lines high
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_data_q <= {periph_pkg::DATA_W{1'b1}};
        end else if (lpt_write) begin
            lpt_data_q <= data_i;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_bus_o     <= '0;
            from_chipset_o <= 1'b0;
        end else if (ems_read) begin
            data_bus_o     <= ems_data_i;
            from_chipset_o <= 1'b1;
        end else if (lpt_read) begin
            data_bus_o     <= lpt_data_q;
            from_chipset_o <= 1'b1;
        end else begin
            // Bus left to other devices
            data_bus_o     <= '0;
            from_chipset_o <= 1'b0;
        end
    end

endmodule

// ==== hw/peripherals_top.sv ====
// Top of the XT peripheral glue block. Connects the address decoder,
// EMS mapper, keyboard conditioning and CPU readback.

`timescale 1ns/1ps

module peripherals_top #(
    parameter int KEY_SYNC_STAGES = 2
) (
    input  logic                             clock,
    input  logic                             reset,
    // CPU bus
    input  logic [periph_pkg::ADDR_W-1:0]    address_i,
    input  logic [periph_pkg::DATA_W-1:0]    data_i,
    input  logic                             io_read_n_i,
    input  logic                             io_write_n_i,
    input  logic                             address_enable_n_i,
    output logic [periph_pkg::DATA_W-1:0]    data_bus_o,
    output logic                             from_chipset_o,
    // Chip selects
    output logic                             dma_cs_n_o,
    output logic                             pic_cs_n_o,
    output logic                             pit_cs_n_o,
    output logic                             ppi_cs_n_o,
    output logic                             dma_page_cs_n_o,
    output logic                             bios_cs_n_o,
    output logic                             xtide_cs_n_o,
    // EMS
    input  logic                             ems_enabled_i,
    input  logic [1:0]                       ems_base_i,
    output logic [periph_pkg::EMS_PAGES-1:0] window_hit_o,
    // Keyboard
    input  logic [periph_pkg::DATA_W-1:0]    keycode_i,
    input  logic                             keyboard_irq_i,
    input  logic [periph_pkg::DATA_W-1:0]    port_b_i,
    input  logic                             tandy_mode_i,
    input  logic                             ps2_send_clock_i,
    output logic [periph_pkg::DATA_W-1:0]    port_a_o,
    output logic                             keyboard_interrupt_o,
    output logic                             send_request_o,
    output logic                             ps2_clock_out_o
);

    periph_pkg::io_target_e        target;
    logic [periph_pkg::DATA_W-1:0] ems_read_data;

    io_decoder u_io_decoder (
        .address_i          (address_i),
        .address_enable_n_i (address_enable_n_i),
        .io_read_n_i        (io_read_n_i),
        .io_write_n_i       (io_write_n_i),
        .ems_enabled_i      (ems_enabled_i),
        .target_o           (target),
        .dma_cs_n_o         (dma_cs_n_o),
        .pic_cs_n_o         (pic_cs_n_o),
        .pit_cs_n_o         (pit_cs_n_o),
        .ppi_cs_n_o         (ppi_cs_n_o),
        .dma_page_cs_n_o    (dma_page_cs_n_o),
        .bios_cs_n_o        (bios_cs_n_o),
        .xtide_cs_n_o       (xtide_cs_n_o)
    );

    ems_mapper u_ems_mapper (
        .clock        (clock),
        .reset        (reset),
        .address_i    (address_i),
        .data_i       (data_i),
        .io_write_n_i (io_write_n_i),
        .io_read_n_i  (io_read_n_i),
        .target_i     (target),
        .ems_base_i   (ems_base_i),
        .read_data_o  (ems_read_data),
        .window_hit_o (window_hit_o)
    );

    keyboard_glue #(
        .KEY_SYNC_STAGES (KEY_SYNC_STAGES)
    ) u_keyboard_glue (
        .clock                (clock),
        .reset                (reset),
        .keycode_i            (keycode_i),
        .keyboard_irq_i       (keyboard_irq_i),
        .port_b_i             (port_b_i),
        .tandy_mode_i         (tandy_mode_i),
        .ps2_send_clock_i     (ps2_send_clock_i),
        .port_a_o             (port_a_o),
        .keyboard_interrupt_o (keyboard_interrupt_o),
        .send_request_o       (send_request_o),
        .ps2_clock_out_o      (ps2_clock_out_o)
    );

    bus_readback u_bus_readback (
        .clock          (clock),
        .reset          (reset),
        .target_i       (target),
        .io_read_n_i    (io_read_n_i),
        .io_write_n_i   (io_write_n_i),
        .data_i         (data_i),
        .ems_data_i     (ems_read_data),
        .data_bus_o     (data_bus_o),
        .from_chipset_o (from_chipset_o)
    );

endmodule

// ==== tb/tb_checks.svh ====
// Compare tasks and error counters for the peripheral testbench.
// Included inside the testbench module, one task per kind of result.
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int error_count = 0;
int check_count = 0;

// Single-bit outputs such as selects and flags
task automatic check_bit(input string name, input logic got, input logic expected);
    check_count++;
    if (got !== expected) begin
        error_count++;
        $display("ERR %0t %s got %b expected %b", $time, name, got, expected);
    end
endtask

task automatic check_byte(input string name,
                          input logic [periph_pkg::DATA_W-1:0] got,
                          input logic [periph_pkg::DATA_W-1:0] expected);
    check_count++;
    if (got !== expected) begin
        error_count++;
        $display("ERR %0t %s got %h expected %h", $time, name, got, expected);
    end
endtask

// EMS window hit vector, one bit per page
task automatic check_hits(input string name,
                          input logic [periph_pkg::EMS_PAGES-1:0] got,
                          input logic [periph_pkg::EMS_PAGES-1:0] expected);
    check_count++;
    if (got !== expected) begin
        error_count++;
        $display("ERR %0t %s got %b expected %b", $time, name, got, expected);
    end
endtask

`endif

// ==== tb/tb_peripherals.sv ====
// Directed testbench for the XT peripheral glue block. Covers address
// decode, EMS mapper, LPT latch, readback and the keyboard path.

`timescale 1ns/1ps

module tb_peripherals;

    // Upper bound on the length of all directed tests in clock cycles
    localparam int TEST_CYCLES    = 1000;
    localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;
    localparam logic [periph_pkg::ADDR_W-1:0] LPT_PORT = {4'h0, periph_pkg::LPT_IO_ADDR};

    logic                             clock = 1'b0;
    logic                             reset;
    logic [periph_pkg::ADDR_W-1:0]    address_i;
    logic [periph_pkg::DATA_W-1:0]    data_i;
    logic                             io_read_n_i;
    logic                             io_write_n_i;
    logic                             address_enable_n_i;
    logic                             ems_enabled_i;
    logic [1:0]                       ems_base_i;
    logic [periph_pkg::DATA_W-1:0]    keycode_i;
    logic                             keyboard_irq_i;
    logic [periph_pkg::DATA_W-1:0]    port_b_i;
    logic                             tandy_mode_i;
    logic                             ps2_send_clock_i;
    logic [periph_pkg::DATA_W-1:0]    data_bus_o;
    logic                             from_chipset_o;
    logic                             dma_cs_n_o;
    logic                             pic_cs_n_o;
    logic                             pit_cs_n_o;
    logic                             ppi_cs_n_o;
    logic                             dma_page_cs_n_o;
    logic                             bios_cs_n_o;
    logic                             xtide_cs_n_o;
    logic [periph_pkg::EMS_PAGES-1:0] window_hit_o;
    logic [periph_pkg::DATA_W-1:0]    port_a_o;
    logic                             keyboard_interrupt_o;
    logic                             send_request_o;
    logic                             ps2_clock_out_o;

    // Expected page state as the EMS write rules leave it
    logic [periph_pkg::EMS_MAP_W-1:0] exp_map [periph_pkg::EMS_PAGES];
    logic [periph_pkg::EMS_PAGES-1:0] exp_en = '0;
    logic [31:0]                      lcg_state = 32'hef6a8884;
    int                               cycle_count = 0;

    `include "tb_checks.svh"

    peripherals_top #(.KEY_SYNC_STAGES(2)) UUT (.*);

    always #20 clock = ~clock;

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic logic [7:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:24];
    endfunction

    function automatic logic [periph_pkg::ADDR_W-1:0] ems_port(input logic [1:0] k);
        return {4'h0, periph_pkg::EMS_IO_BASE + {14'h0, k}};
    endfunction

    function automatic logic [periph_pkg::DATA_W-1:0] ems_expected(input logic [1:0] k);
        return exp_en[k] ? {1'b0, exp_map[k]} : 8'hFF;
    endfunction

    task automatic drive_bus(input logic [periph_pkg::ADDR_W-1:0] addr,
                             input logic [periph_pkg::DATA_W-1:0] wdata,
                             input logic rd_n,
                             input logic wr_n,
                             input logic aen_n);
        @(posedge clock);
        address_i          <= addr;
        data_i             <= wdata;
        io_read_n_i        <= rd_n;
        io_write_n_i       <= wr_n;
        address_enable_n_i <= aen_n;
    endtask

    task automatic release_bus();
        @(posedge clock);
        io_read_n_i        <= 1'b1;
        io_write_n_i       <= 1'b1;
        address_enable_n_i <= 1'b1;
    endtask

    // Readback is registered at the edge that ends the read
    task automatic io_read(input logic [periph_pkg::ADDR_W-1:0] addr,
                           input logic [periph_pkg::DATA_W-1:0] exp_data,
                           input logic exp_flag);
        drive_bus(addr, '0, 1'b0, 1'b1, 1'b0);
        release_bus();
        @(negedge clock);
        check_byte("data_bus_o", data_bus_o, exp_data);
        check_bit("from_chipset_o", from_chipset_o, exp_flag);
    endtask

    task automatic ems_write(input logic [1:0] k, input logic [periph_pkg::DATA_W-1:0] d);
        drive_bus(ems_port(k), d, 1'b1, 1'b0, 1'b0);
        release_bus();
        if (ems_enabled_i) begin
            if (d == 8'hFF) begin
                exp_en[k]  = 1'b0;
                exp_map[k] = 7'h7F;
            end else if (d < 8'h80) begin
                exp_en[k]  = 1'b1;
                exp_map[k] = d[6:0];
            end
        end
    endtask

    task automatic verify_selects(input logic [4:0] exp_n);
        check_bit("dma_cs_n_o", dma_cs_n_o, exp_n[0]);
        check_bit("pic_cs_n_o", pic_cs_n_o, exp_n[1]);
        check_bit("pit_cs_n_o", pit_cs_n_o, exp_n[2]);
        check_bit("ppi_cs_n_o", ppi_cs_n_o, exp_n[3]);
        check_bit("dma_page_cs_n_o", dma_page_cs_n_o, exp_n[4]);
    endtask

    task automatic idle_outputs();
        check_byte("data_bus_o", data_bus_o, 8'h00);
        check_bit("from_chipset_o", from_chipset_o, 1'b0);
        check_hits("window_hit_o", window_hit_o, '0);
        check_bit("keyboard_interrupt_o", keyboard_interrupt_o, 1'b0);
        check_bit("send_request_o", send_request_o, 1'b0);
        check_bit("ps2_clock_out_o", ps2_clock_out_o, 1'b1);
    endtask

    task automatic address_decode();
        logic [periph_pkg::ADDR_W-1:0] addr;
        logic [7:0]                    rnd;
        logic [4:0]                    exp_n;
        logic                          aen_n;
        logic                          mem;
        for (int blk = 0; blk < 8; blk++) begin
            for (int n = 0; n < 4; n++) begin
                rnd   = next_random();
                addr  = {12'h000, 3'(blk), rnd[4:0]};
                // Blocks 5 to 7 select nothing
                exp_n = (blk < 5) ? ~(5'b00001 << blk) : 5'b11111;
                drive_bus(addr, '0, 1'b0, 1'b1, 1'b0);
                @(negedge clock);
                verify_selects(exp_n);
                drive_bus(addr, '0, 1'b0, 1'b1, 1'b1);
                @(negedge clock);
                verify_selects(5'b11111);
                addr[9:8] = 2'(n % 3 + 1);
                drive_bus(addr, '0, 1'b0, 1'b1, 1'b0);
                @(negedge clock);
                verify_selects(5'b11111);
            end
        end
        for (int n = 0; n < 12; n++) begin
            rnd   = next_random();
            addr  = {rnd[5:0], 14'(n * 1237)};
            // Steer most addresses into or next to a ROM window
            case (n % 4)
                0: addr[19:16] = 4'hF;
                1: addr[19:14] = 6'b111011;
                2: addr[19:14] = 6'b111010;
                default: ;
            endcase
            aen_n = (n % 3 == 2);
            for (int io = 0; io < 2; io++) begin
                mem = !aen_n && (io == 0);
                drive_bus(addr, '0, (io == 0), 1'b1, aen_n);
                @(negedge clock);
                check_bit("bios_cs_n_o", bios_cs_n_o, !(mem && addr[19:16] == 4'hF));
                check_bit("xtide_cs_n_o", xtide_cs_n_o, !(mem && addr[19:14] == 6'b111011));
            end
        end
        release_bus();
    endtask

    task automatic page_write_rules();
        logic [periph_pkg::DATA_W-1:0] d;
        @(posedge clock);
        ems_enabled_i <= 1'b1;
        for (int k = 0; k < 4; k++) begin
            io_read(ems_port(2'(k)), 8'hFF, 1'b1);
            d = next_random() & 8'h7F;
            ems_write(2'(k), d);
            io_read(ems_port(2'(k)), ems_expected(2'(k)), 1'b1);
            // 80..FE must not touch the page
            d = next_random() | 8'h80;
            if (d == 8'hFF) begin
                d = 8'hFE;
            end
            ems_write(2'(k), d);
            io_read(ems_port(2'(k)), ems_expected(2'(k)), 1'b1);
            ems_write(2'(k), 8'hFF);
            io_read(ems_port(2'(k)), 8'hFF, 1'b1);
            d = next_random() & 8'h7F;
            ems_write(2'(k), d);
            io_read(ems_port(2'(k)), ems_expected(2'(k)), 1'b1);
        end
        @(posedge clock);
        ems_enabled_i <= 1'b0;
        ems_write(2'd0, 8'h15);
        // Port not decoded while EMS is off
        io_read(ems_port(2'd0), 8'h00, 1'b0);
        @(posedge clock);
        ems_enabled_i <= 1'b1;
        io_read(ems_port(2'd0), ems_expected(2'd0), 1'b1);
    endtask

    task automatic page_windows();
        logic [periph_pkg::ADDR_W-1:0]    addr;
        logic [7:0]                       rnd;
        logic [3:0]                       nib;
        logic [1:0]                       kk;
        logic [periph_pkg::EMS_PAGES-1:0] exp_hits;
        // Pages 0 and 2 stay mapped
        ems_write(2'd1, 8'hFF);
        ems_write(2'd3, 8'hFF);
        for (int b = 0; b < 4; b++) begin
            @(posedge clock);
            ems_base_i <= 2'(b);
            nib = (b == 0) ? 4'hA : ((b == 1) ? 4'hC : 4'hD);
            for (int k = 0; k < 4; k++) begin
                kk       = 2'(k);
                rnd      = next_random();
                addr     = {nib, kk, rnd, 6'(k * 11)};
                exp_hits = exp_en[kk] ? (4'b0001 << kk) : 4'b0000;
                drive_bus(addr, '0, 1'b1, 1'b1, 1'b0);
                @(negedge clock);
                check_hits("window_hit_o", window_hit_o, exp_hits);
                drive_bus(addr, '0, 1'b0, 1'b1, 1'b0);
                @(negedge clock);
                check_hits("window_hit_o", window_hit_o, '0);
            end
            // B000 is never a frame segment
            drive_bus({4'hB, 2'd0, 14'h0}, '0, 1'b1, 1'b1, 1'b0);
            @(negedge clock);
            check_hits("window_hit_o", window_hit_o, '0);
        end
        release_bus();
    endtask

    task automatic lpt_readback();
        logic [periph_pkg::DATA_W-1:0] d;
        io_read(LPT_PORT, 8'hFF, 1'b1);
        d = next_random();
        drive_bus(LPT_PORT, d, 1'b1, 1'b0, 1'b0);
        release_bus();
        io_read(LPT_PORT, d, 1'b1);
        io_read({4'h0, 16'h0300}, 8'h00, 1'b0);
    endtask

    task automatic reset_request(input logic tandy, input logic exp_pulse);
        @(posedge clock);
        tandy_mode_i <= tandy;
        port_b_i     <= 8'h00;
        @(posedge clock);
        port_b_i     <= 8'h40;
        @(negedge clock);
        // Request waits for the next edge
        check_bit("send_request_o", send_request_o, 1'b0);
        @(negedge clock);
        check_bit("send_request_o", send_request_o, exp_pulse);
        repeat (3) begin
            @(negedge clock);
            check_bit("send_request_o", send_request_o, 1'b0);
        end
    endtask

    task automatic keyboard_path();
        logic [periph_pkg::DATA_W-1:0] key;
        logic [3:0]                    combo;
        logic                          exp_clk;
        key = next_random();
        @(posedge clock);
        keycode_i <= key;
        repeat (2) @(negedge clock);
        check_byte("port_a_o", port_a_o, 8'h00);
        @(negedge clock);
        check_byte("port_a_o", port_a_o, key);
        @(posedge clock);
        keyboard_irq_i <= 1'b1;
        repeat (2) @(negedge clock);
        check_bit("keyboard_interrupt_o", keyboard_interrupt_o, 1'b0);
        @(negedge clock);
        check_bit("keyboard_interrupt_o", keyboard_interrupt_o, 1'b1);
        // Irq is still high, so the PS/2 clock is inhibited
        exp_clk = 1'b0;
        // Irq, sender clock, port B bit 6 and Tandy mode in all combinations
        for (int c = 0; c < 16; c++) begin
            combo = 4'(c);
            @(posedge clock);
            keyboard_irq_i   <= combo[0];
            ps2_send_clock_i <= combo[1];
            port_b_i         <= {1'b0, combo[2], 6'h00};
            tandy_mode_i     <= combo[3];
            @(negedge clock);
            check_bit("ps2_clock_out_o", ps2_clock_out_o, exp_clk);
            exp_clk = !(combo[0] || !combo[1] || !(combo[3] || combo[2]));
            @(negedge clock);
            check_bit("ps2_clock_out_o", ps2_clock_out_o, exp_clk);
        end
        reset_request(1'b0, 1'b1);
        reset_request(1'b1, 1'b0);
    endtask

    initial begin
        reset              <= 1'b1;
        address_i          <= '0;
        data_i             <= '0;
        io_read_n_i        <= 1'b1;
        io_write_n_i       <= 1'b1;
        address_enable_n_i <= 1'b1;
        ems_enabled_i      <= 1'b0;
        ems_base_i         <= 2'd0;
        keycode_i          <= '0;
        keyboard_irq_i     <= 1'b0;
        // Keyboard out of reset with the sender clock idle high
        port_b_i           <= 8'h40;
        tandy_mode_i       <= 1'b0;
        ps2_send_clock_i   <= 1'b1;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        idle_outputs();
        address_decode();
        page_write_rules();
        page_windows();
        lpt_readback();
        keyboard_path();
        repeat (2) @(posedge clock);
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hw/periph_pkg.sv
hw/io_decoder.sv
hw/ems_mapper.sv
hw/keyboard_glue.sv
hw/bus_readback.sv
hw/peripherals_top.sv
tb/tb_peripherals.sv
+incdir+tb

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the peripheral testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_peripherals -f all.f -o tb_peripherals
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_peripherals)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
